// File: common/soc_pkg.sv
package soc_pkg;

	// Bus widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	// AXI response codes
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

	// Address map, base plus span of each window
	localparam addr_t RAM_BASE   = 32'h0000_0000;
	localparam addr_t RAM_SPACE  = 32'h0000_07ff;
	localparam addr_t BOOT_BASE  = 32'h0001_0000;
	localparam addr_t BOOT_SPACE = 32'h0000_00ff;
	localparam addr_t UART_BASE  = 32'h0001_0100;
	localparam addr_t UART_SPACE = 32'h0000_00ff;

	// Slave ports on the decoder
	localparam int N_SLV = 3;
	typedef logic [1:0] slv_idx_t;
	localparam slv_idx_t RAM_IDX  = 2'd0;
	localparam slv_idx_t BOOT_IDX = 2'd1;
	localparam slv_idx_t UART_IDX = 2'd2;

	// On-chip RAM
	localparam int RAM_WORDS = 512;
	typedef logic [$clog2(RAM_WORDS)-1:0] ram_idx_t;

	// Boot controller registers
	typedef logic [7:0] reg_ofs_t;
	localparam reg_ofs_t BOOT_SRC_OFS     = 8'h00; // Strap readback
	localparam reg_ofs_t BOOT_SCRATCH_OFS = 8'h04;
	typedef logic [1:0] boot_src_t; // 0 SPI, 1 SRAM, 2 DDR

	// UART bit timing
	localparam int CLKS_PER_BIT = 8;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;
	localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);

	// Master to slave
	typedef struct packed {
		logic  aw_valid;
		addr_t aw_addr;
		logic  w_valid;
		data_t w_data;
		strb_t w_strb;
		logic  b_ready;
		logic  ar_valid;
		addr_t ar_addr;
		logic  r_ready;
	} axi_req_t;

	// Slave to master
	typedef struct packed {
		logic  aw_ready;
		logic  w_ready;
		logic  b_valid;
		resp_t b_resp;
		logic  ar_ready;
		logic  r_valid;
		data_t r_data;
		resp_t r_resp;
	} axi_rsp_t;

endpackage

// File: interconnect/axi_decoder.sv
`timescale 1ns/100ps

module axi_decoder import soc_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  axi_req_t             m_req_i,
	output axi_rsp_t             m_rsp_o,
	output axi_req_t [N_SLV-1:0] s_req_o,
	input  axi_rsp_t [N_SLV-1:0] s_rsp_i
);

	// Offset wraps above space when addr is below base
	function automatic logic in_win(input addr_t addr, input addr_t base, input addr_t space);
		return (addr - base) <= space;
	endfunction

	// Hit flag, slave index through idx
	function automatic logic map_addr(input addr_t addr, output slv_idx_t idx);
		idx = RAM_IDX; // Harmless default on a miss
		if (in_win(addr, BOOT_BASE, BOOT_SPACE)) idx = BOOT_IDX;
		if (in_win(addr, UART_BASE, UART_SPACE)) idx = UART_IDX;
		return in_win(addr, RAM_BASE, RAM_SPACE) || in_win(addr, BOOT_BASE, BOOT_SPACE) ||
			in_win(addr, UART_BASE, UART_SPACE);
	endfunction

	logic     ar_hit, aw_hit;
	slv_idx_t ar_idx, aw_idx;
	logic     rd_busy_q, rd_err_q, wr_busy_q, wr_err_q; // One outstanding per direction
	slv_idx_t rd_sel_q, wr_sel_q;
	logic     rd_hs, r_done, wr_hs, b_done;

	always_comb begin
		ar_hit = map_addr(m_req_i.ar_addr, ar_idx);
		aw_hit = map_addr(m_req_i.aw_addr, aw_idx);
	end

	// Payload to every slave, valids and readies only to the chosen one
	always_comb begin
		for (int i = 0; i < N_SLV; i++) begin
			s_req_o[i]          = m_req_i;
			s_req_o[i].ar_valid = 1'b0;
			s_req_o[i].aw_valid = 1'b0;
			s_req_o[i].w_valid  = 1'b0;
			s_req_o[i].r_ready  = 1'b0;
			s_req_o[i].b_ready  = 1'b0;
		end
		if (!rd_busy_q && ar_hit) s_req_o[ar_idx].ar_valid = m_req_i.ar_valid;
		if (rd_busy_q && !rd_err_q) s_req_o[rd_sel_q].r_ready = m_req_i.r_ready;
		if (!wr_busy_q && aw_hit) begin
			s_req_o[aw_idx].aw_valid = m_req_i.aw_valid;
			s_req_o[aw_idx].w_valid  = m_req_i.w_valid;
		end
		if (wr_busy_q && !wr_err_q) s_req_o[wr_sel_q].b_ready = m_req_i.b_ready;
	end

	always_comb begin
		m_rsp_o = '0;
		if (!rd_busy_q) begin
			m_rsp_o.ar_ready = ar_hit ? s_rsp_i[ar_idx].ar_ready : 1'b1; // Miss taken locally
		end else if (rd_err_q) begin
			m_rsp_o.r_valid = 1'b1;        // r_data stays zero
			m_rsp_o.r_resp  = RESP_DECERR;
		end else begin
			m_rsp_o.r_valid = s_rsp_i[rd_sel_q].r_valid;
			m_rsp_o.r_data  = s_rsp_i[rd_sel_q].r_data;
			m_rsp_o.r_resp  = s_rsp_i[rd_sel_q].r_resp;
		end
		if (!wr_busy_q) begin
			m_rsp_o.aw_ready = aw_hit ? s_rsp_i[aw_idx].aw_ready : 1'b1;
			m_rsp_o.w_ready  = aw_hit ? s_rsp_i[aw_idx].w_ready : 1'b1;
		end else if (wr_err_q) begin
			m_rsp_o.b_valid = 1'b1;
			m_rsp_o.b_resp  = RESP_DECERR;
		end else begin
			m_rsp_o.b_valid = s_rsp_i[wr_sel_q].b_valid;
			m_rsp_o.b_resp  = s_rsp_i[wr_sel_q].b_resp;
		end
	end

	assign rd_hs  = m_req_i.ar_valid && m_rsp_o.ar_ready;
	assign r_done = m_rsp_o.r_valid && m_req_i.r_ready;
	assign wr_hs  = m_req_i.aw_valid && m_req_i.w_valid && m_rsp_o.aw_ready && m_rsp_o.w_ready;
	assign b_done = m_rsp_o.b_valid && m_req_i.b_ready;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_busy_q <= 1'b0;
			rd_err_q  <= 1'b0;
			rd_sel_q  <= RAM_IDX;
			wr_busy_q <= 1'b0;
			wr_err_q  <= 1'b0;
			wr_sel_q  <= RAM_IDX;
		end else begin
			if (rd_hs) begin
				rd_busy_q <= 1'b1;
				rd_err_q  <= !ar_hit;
				rd_sel_q  <= ar_idx;
			end else if (r_done) begin
				rd_busy_q <= 1'b0;
			end
			if (wr_hs) begin
				wr_busy_q <= 1'b1;
				wr_err_q  <= !aw_hit;
				wr_sel_q  <= aw_idx;
			end else if (b_done) begin
				wr_busy_q <= 1'b0;
			end
		end
	end

endmodule

// File: hdl/axi_ram.sv
`timescale 1ns/100ps

module axi_ram import soc_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  axi_req_t req_i,
	output axi_rsp_t rsp_o
);

	data_t    mem_q [RAM_WORDS];
	data_t    r_data_q;
	logic     r_valid_q, b_valid_q;
	logic     rd_hs, wr_hs;
	ram_idx_t rd_idx, wr_idx;

	// Word index above the byte offset, upper bits ignored
	assign rd_idx = req_i.ar_addr[2 +: $bits(ram_idx_t)];
	assign wr_idx = req_i.aw_addr[2 +: $bits(ram_idx_t)];

	assign rd_hs = req_i.ar_valid && !r_valid_q;
	assign wr_hs = req_i.aw_valid && req_i.w_valid && !b_valid_q;

	always_comb begin
		rsp_o          = '0;
		rsp_o.ar_ready = !r_valid_q; // Free while no read response waits
		rsp_o.r_valid  = r_valid_q;
		rsp_o.r_data   = r_data_q;
		rsp_o.r_resp   = RESP_OKAY;
		rsp_o.aw_ready = !b_valid_q;
		rsp_o.w_ready  = !b_valid_q; // Together with aw_ready
		rsp_o.b_valid  = b_valid_q;
		rsp_o.b_resp   = RESP_OKAY;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (rd_hs) r_valid_q <= 1'b1;
			else if (req_i.r_ready) r_valid_q <= 1'b0;
			if (wr_hs) b_valid_q <= 1'b1;
			else if (req_i.b_ready) b_valid_q <= 1'b0;
		end
	end

	// Byte lanes follow the strobes
	always_ff @(posedge clk_i) begin
		if (wr_hs) begin
			for (int b = 0; b < $bits(strb_t); b++) begin
				if (req_i.w_strb[b]) mem_q[wr_idx][b*8 +: 8] <= req_i.w_data[b*8 +: 8];
			end
		end
		if (rd_hs) r_data_q <= mem_q[rd_idx]; // Held until r_ready
	end

endmodule

// File: hdl/boot_ctrl.sv
`timescale 1ns/100ps

module boot_ctrl import soc_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  boot_src_t boot_source_i,
	input  axi_req_t  req_i,
	output axi_rsp_t  rsp_o
);

	data_t    scratch_q, r_data_q;
	resp_t    b_resp_q;
	logic     r_valid_q, b_valid_q, rd_hs, wr_hs;
	reg_ofs_t rd_ofs, wr_ofs;

	assign rd_ofs = req_i.ar_addr[7:0];
	assign wr_ofs = req_i.aw_addr[7:0];
	assign rd_hs  = req_i.ar_valid && !r_valid_q;
	assign wr_hs  = req_i.aw_valid && req_i.w_valid && !b_valid_q;

	always_comb begin
		rsp_o          = '0;
		rsp_o.ar_ready = !r_valid_q;
		rsp_o.r_valid  = r_valid_q;
		rsp_o.r_data   = r_data_q;
		rsp_o.r_resp   = RESP_OKAY;
		rsp_o.aw_ready = !b_valid_q;
		rsp_o.w_ready  = !b_valid_q;
		rsp_o.b_valid  = b_valid_q;
		rsp_o.b_resp   = b_resp_q;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
			scratch_q <= '0;
		end else begin
			if (rd_hs) r_valid_q <= 1'b1;
			else if (req_i.r_ready) r_valid_q <= 1'b0;
			if (wr_hs) b_valid_q <= 1'b1;
			else if (req_i.b_ready) b_valid_q <= 1'b0;
			for (int b = 0; b < $bits(strb_t); b++) begin // Scratch written per byte
				if (wr_hs && wr_ofs == BOOT_SCRATCH_OFS && req_i.w_strb[b])
					scratch_q[b*8 +: 8] <= req_i.w_data[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_hs) begin
			if (rd_ofs == BOOT_SRC_OFS) r_data_q <= data_t'(boot_source_i); // Zero-extended
			else if (rd_ofs == BOOT_SCRATCH_OFS) r_data_q <= scratch_q;
			else r_data_q <= '0;
		end
		if (wr_hs) b_resp_q <= (wr_ofs == BOOT_SRC_OFS) ? RESP_SLVERR : RESP_OKAY; // Straps read-only
	end

endmodule

// File: uart/axi_uart_tx.sv
`timescale 1ns/100ps

module axi_uart_tx import soc_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  axi_req_t req_i,
	output axi_rsp_t rsp_o,
	output logic     tx_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} tx_state_e;

	tx_state_e state_q;
	baud_cnt_t baud_cnt_q;
	logic [2:0] bit_idx_q;   // Data bit in flight
	logic [7:0] shift_q;     // LSB goes out next
	logic       tx_q, r_valid_q, b_valid_q, busy_rd_q;
	logic       bit_end, busy, wr_rdy, rd_hs, wr_hs;

	assign busy    = (state_q != ST_IDLE);
	assign bit_end = (baud_cnt_q == BAUD_LAST);
	assign wr_rdy  = !busy && !b_valid_q;   // Stalls writes until the frame is out
	assign rd_hs   = req_i.ar_valid && !r_valid_q;
	assign wr_hs   = req_i.aw_valid && req_i.w_valid && wr_rdy;
	assign tx_o    = tx_q;

	always_comb begin
		rsp_o          = '0;
		rsp_o.ar_ready = !r_valid_q;
		rsp_o.r_valid  = r_valid_q;
		rsp_o.r_data   = data_t'(busy_rd_q); // Busy flag in bit 0
		rsp_o.r_resp   = RESP_OKAY;
		rsp_o.aw_ready = wr_rdy;
		rsp_o.w_ready  = wr_rdy;
		rsp_o.b_valid  = b_valid_q;
		rsp_o.b_resp   = RESP_OKAY;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= ST_IDLE;
			baud_cnt_q <= '0;
			bit_idx_q  <= '0;
			tx_q       <= 1'b1; // Line idles high
			r_valid_q  <= 1'b0;
			b_valid_q  <= 1'b0;
		end else begin
			if (rd_hs) r_valid_q <= 1'b1;
			else if (req_i.r_ready) r_valid_q <= 1'b0;
			if (wr_hs) b_valid_q <= 1'b1;
			else if (req_i.b_ready) b_valid_q <= 1'b0;
			baud_cnt_q <= (!busy || bit_end) ? '0 : baud_cnt_q + 1'b1;
			case (state_q)
				ST_IDLE: if (wr_hs) begin
					state_q <= ST_START;
					tx_q    <= 1'b0;          // Start bit
				end
				ST_START: if (bit_end) begin
					state_q   <= ST_DATA;
					bit_idx_q <= '0;
					tx_q      <= shift_q[0];
				end
				ST_DATA: if (bit_end) begin
					if (bit_idx_q == 3'd7) begin
						state_q <= ST_STOP;
						tx_q    <= 1'b1;      // Stop bit
					end else begin
						bit_idx_q <= bit_idx_q + 1'b1;
						tx_q      <= shift_q[1]; // Next bit before the shift lands
					end
				end
				default: if (bit_end) state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_hs) shift_q <= req_i.w_data[7:0];
		else if (state_q == ST_DATA && bit_end) shift_q <= shift_q >> 1;
		if (rd_hs) busy_rd_q <= busy; // Frozen while r_valid waits
	end

endmodule

// File: hdl/soc_top.sv
`timescale 1ns/100ps

module soc_top import soc_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  boot_src_t boot_source_i, // Strap pins
	input  axi_req_t  m_req_i,       // External AXI-lite master
	output axi_rsp_t  m_rsp_o,
	output logic      tx_o           // Serial line
);

	// One request/response pair per slave port
	axi_req_t [N_SLV-1:0] slv_req;
	axi_rsp_t [N_SLV-1:0] slv_rsp;

	axi_decoder u_axi_decoder (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.m_req_i (m_req_i),
		.m_rsp_o (m_rsp_o),
		.s_req_o (slv_req),
		.s_rsp_i (slv_rsp)
	);

	// 2 KiB on-chip RAM
	axi_ram u_axi_ram (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.req_i   (slv_req[RAM_IDX]),
		.rsp_o   (slv_rsp[RAM_IDX])
	);

	boot_ctrl u_boot_ctrl (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.boot_source_i (boot_source_i),
		.req_i         (slv_req[BOOT_IDX]),
		.rsp_o         (slv_rsp[BOOT_IDX])
	);

	// Transmit only
	axi_uart_tx u_axi_uart_tx (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.req_i   (slv_req[UART_IDX]),
		.rsp_o   (slv_rsp[UART_IDX]),
		.tx_o    (tx_o)
	);

endmodule

// File: tests/soc_asserts.sv
`timescale 1ns/100ps

module soc_asserts import soc_pkg::*; (
	input logic     clk_i,
	input logic     rst_n_i,
	input axi_req_t req_i,
	input axi_rsp_t rsp_i,
	input logic     tx_i
);

	// Read response and its data frozen until the master takes it
	r_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rsp_i.r_valid && !req_i.r_ready |=> rsp_i.r_valid && $stable(rsp_i.r_data))
		else $error("r_valid dropped or r_data changed before r_ready");

	b_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rsp_i.b_valid && !req_i.b_ready |=> rsp_i.b_valid) // Write response held
		else $error("b_valid dropped before b_ready");

	// Serial line idles high in reset
	tx_rst_a: assert property (@(posedge clk_i) !rst_n_i |-> tx_i)
		else $error("tx line low during reset");

endmodule

// File: tests/soc_checker.sv
`timescale 1ns/100ps

module soc_checker import soc_pkg::*; (
	input logic      clk_i,
	input logic      rst_n_i,
	input boot_src_t boot_source_i,
	input axi_req_t  req_i,
	input axi_rsp_t  rsp_i,
	input logic      tx_i
);

	data_t      ram_q [RAM_WORDS];        // Shadow RAM
	strb_t      ram_known_q [RAM_WORDS] = '{default: '0}; // Bytes written so far
	data_t      scratch_q = '0;
	data_t      rd_data_q[$], rd_mask_q[$]; // One entry per accepted read
	resp_t      rd_resp_q[$], wr_resp_q[$];
	logic [7:0] tx_exp_q[$];              // Bytes still to appear on tx
	string      cur_test = "none";
	int         checks, test_errs, errors, tests_run, tests_failed, bytes_left;

	function automatic logic inside_range(input addr_t a, input addr_t base, input addr_t span);
		return a >= base && a <= base + span;
	endfunction

	function automatic data_t byte_mask(input strb_t strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	task automatic check_val(input string what, input data_t exp, input data_t act);
		checks++;
		if (exp !== act) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errs++;
			errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		test_errs++;
		errors++;
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (rd_resp_q.size() != 0 || wr_resp_q.size() != 0)
			report_error("responses still outstanding at end of test");
		if (tx_exp_q.size() != 0) report_error("bytes written but never sent on tx");
		tests_run++;
		if (test_errs != 0) tests_failed++;
		$display("Test %s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED",
			test_errs);
	endtask

	// Expected read result, taken at the AR handshake
	task automatic expect_read(input addr_t a);
		ram_idx_t idx;
		idx = ram_idx_t'((a - RAM_BASE) >> 2); // Bits above the index ignored
		if (inside_range(a, RAM_BASE, RAM_SPACE)) begin
			rd_data_q.push_back(ram_q[idx]);
			rd_mask_q.push_back(byte_mask(ram_known_q[idx])); // Unwritten bytes unknown
			rd_resp_q.push_back(RESP_OKAY);
		end else if (inside_range(a, BOOT_BASE, BOOT_SPACE)) begin
			if (a - BOOT_BASE == 0) rd_data_q.push_back(data_t'(boot_source_i));
			else if (a - BOOT_BASE == 4) rd_data_q.push_back(scratch_q);
			else rd_data_q.push_back(data_t'(0));
			rd_mask_q.push_back(32'hffff_ffff);
			rd_resp_q.push_back(RESP_OKAY);
		end else if (inside_range(a, UART_BASE, UART_SPACE)) begin
			rd_data_q.push_back(data_t'(0));
			rd_mask_q.push_back(32'hffff_fffe); // Busy bit not modeled
			rd_resp_q.push_back(RESP_OKAY);
		end else begin
			rd_data_q.push_back(data_t'(0));
			rd_mask_q.push_back(32'hffff_ffff);
			rd_resp_q.push_back(RESP_DECERR);
		end
	endtask

	task automatic expect_write(input addr_t a, input data_t d, input strb_t s);
		ram_idx_t idx;
		data_t    m;
		idx = ram_idx_t'((a - RAM_BASE) >> 2);
		m   = byte_mask(s);
		if (inside_range(a, RAM_BASE, RAM_SPACE)) begin
			ram_q[idx]       = (ram_q[idx] & ~m) | (d & m);
			ram_known_q[idx] = ram_known_q[idx] | s;
			wr_resp_q.push_back(RESP_OKAY);
		end else if (inside_range(a, BOOT_BASE, BOOT_SPACE)) begin
			if (a - BOOT_BASE == 4) scratch_q = (scratch_q & ~m) | (d & m);
			wr_resp_q.push_back((a - BOOT_BASE == 0) ? RESP_SLVERR : RESP_OKAY); // Straps read-only
		end else if (inside_range(a, UART_BASE, UART_SPACE)) begin
			tx_exp_q.push_back(d[7:0]);
			bytes_left++;
			wr_resp_q.push_back(RESP_OKAY);
		end else begin
			wr_resp_q.push_back(RESP_DECERR);
		end
	endtask

	task automatic check_read();
		data_t m;
		if (rd_resp_q.size() == 0) begin
			report_error("read response with no read request");
		end else begin
			m = rd_mask_q.pop_front();
			check_val("r_resp", data_t'(rd_resp_q.pop_front()), data_t'(rsp_i.r_resp));
			check_val("r_data", rd_data_q.pop_front() & m, rsp_i.r_data & m);
		end
	endtask

	task automatic check_write();
		if (wr_resp_q.size() == 0) report_error("write response with no write request");
		else check_val("b_resp", data_t'(wr_resp_q.pop_front()), data_t'(rsp_i.b_resp));
	endtask

	// Bus monitor, all handshakes on the master port
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			scratch_q = '0;
		end else begin
			if (req_i.ar_valid && rsp_i.ar_ready) expect_read(req_i.ar_addr);
			if (req_i.aw_valid && req_i.w_valid && rsp_i.aw_ready && rsp_i.w_ready)
				expect_write(req_i.aw_addr, req_i.w_data, req_i.w_strb);
			if (rsp_i.r_valid && req_i.r_ready) check_read();
			if (rsp_i.b_valid && req_i.b_ready) check_write();
		end
	end

	// Serial frame decoder, samples near mid-bit
	initial begin
		logic [7:0] rx;
		forever begin
			@(posedge clk_i);
			if (rst_n_i && tx_i == 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(posedge clk_i);
				if (tx_i !== 1'b0) report_error("start bit on tx shorter than one bit time");
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(posedge clk_i);
					rx[i] = tx_i; // LSB first
				end
				repeat (CLKS_PER_BIT) @(posedge clk_i);
				if (tx_i !== 1'b1) report_error("missing stop bit on tx");
				if (tx_exp_q.size() == 0) begin
					report_error("byte on tx with no write");
				end else begin
					check_val("tx byte", data_t'(tx_exp_q.pop_front()), data_t'(rx));
					bytes_left--;
				end
			end
		end
	end

endmodule

// File: tests/tb_soc_top.sv
`timescale 1ns/100ps

module tb_soc_top import soc_pkg::*; ();

	localparam int TIMEOUT = 400; // Cycles per wait, one frame is about 80

	logic      clk, rst_n, tx;
	boot_src_t boot_source;
	axi_req_t  m_req;
	axi_rsp_t  m_rsp;
	int        seed = 32'h621bdd80;
	addr_t     ram_addrs [200]; // Reused by the back-pressure test

	soc_top u_soc_top (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.boot_source_i (boot_source),
		.m_req_i       (m_req),
		.m_rsp_o       (m_rsp),
		.tx_o          (tx)
	);

	soc_checker u_checker (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.boot_source_i (boot_source),
		.req_i         (m_req),
		.rsp_i         (m_rsp),
		.tx_i          (tx)
	);

	bind soc_top soc_asserts u_soc_asserts (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.req_i   (m_req_i),
		.rsp_i   (m_rsp_o),
		.tx_i    (tx_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic data_t rand_word();
		return $random(seed);
	endfunction

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// AW and W together, then b_ready after a random delay
	task automatic bus_write(input addr_t addr, input data_t data, input strb_t strb, input int dly);
		int n;
		m_req.aw_valid <= 1'b1;
		m_req.aw_addr  <= addr;
		m_req.w_valid  <= 1'b1;
		m_req.w_data   <= data;
		m_req.w_strb   <= strb;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!(m_rsp.aw_ready && m_rsp.w_ready) && n < TIMEOUT);
		if (!(m_rsp.aw_ready && m_rsp.w_ready))
			u_checker.report_error("timeout waiting for aw_ready and w_ready");
		m_req.aw_valid <= 1'b0;
		m_req.w_valid  <= 1'b0;
		repeat (rand_below(dly + 1)) @(posedge clk);
		m_req.b_ready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!m_rsp.b_valid && n < TIMEOUT);
		if (!m_rsp.b_valid) u_checker.report_error("timeout waiting for b_valid");
		m_req.b_ready <= 1'b0;
	endtask

	task automatic bus_read(input addr_t addr, input int dly);
		int n;
		m_req.ar_valid <= 1'b1;
		m_req.ar_addr  <= addr;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!m_rsp.ar_ready && n < TIMEOUT);
		if (!m_rsp.ar_ready) u_checker.report_error("timeout waiting for ar_ready");
		m_req.ar_valid <= 1'b0;
		repeat (rand_below(dly + 1)) @(posedge clk); // r_ready held low meanwhile
		m_req.r_ready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!m_rsp.r_valid && n < TIMEOUT);
		if (!m_rsp.r_valid) u_checker.report_error("timeout waiting for r_valid");
		m_req.r_ready <= 1'b0;
	endtask

	task automatic close_test();
		@(posedge clk); // Checker sees the last handshake first
		u_checker.end_test();
	endtask

	initial begin
		addr_t addr;
		int    n;
		rst_n       = 1'b1;
		boot_source = '0;
		m_req       = '0;
		#1 rst_n = 1'b0; // Falling edge for the async reset
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		u_checker.start_test("ram");
		for (int i = 0; i < 200; i++) begin
			ram_addrs[i] = RAM_BASE + (rand_word() & (RAM_SPACE - 3)); // Word aligned
			bus_write(ram_addrs[i], rand_word(), strb_t'(rand_word()), 2);
		end
		for (int i = 0; i < 200; i++) bus_read(ram_addrs[i], 2);
		close_test();

		u_checker.start_test("boot_strap");
		for (int s = 0; s < 3; s++) begin // SPI, SRAM, DDR
			boot_source <= boot_src_t'(s);
			bus_read(BOOT_BASE, 2);
			bus_write(BOOT_BASE, rand_word(), 4'hf, 2);
		end
		close_test();

		u_checker.start_test("boot_scratch");
		for (int i = 0; i < 20; i++) begin
			bus_write(BOOT_BASE + 4, rand_word(), strb_t'(rand_word()), 2);
			bus_read(BOOT_BASE + 4, 2);
			bus_read(BOOT_BASE + 8 + 4 * rand_below(62), 2); // Offsets 8 to fc
		end
		close_test();

		u_checker.start_test("unmapped");
		for (int i = 0; i < 30; i++) begin
			addr = rand_word() | 32'h0002_0000; // Above every window
			bus_read(addr, 2);
			addr = rand_word() | 32'h0002_0000;
			bus_write(addr, rand_word(), strb_t'(rand_word()), 2);
		end
		close_test();

		u_checker.start_test("uart");
		for (int i = 0; i < 5; i++) bus_write(UART_BASE + (rand_word() & (UART_SPACE - 3)),
			rand_word(), 4'hf, 0);
		n = 0;
		while (u_checker.bytes_left != 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (u_checker.bytes_left != 0) u_checker.report_error("timeout waiting for tx frames");
		close_test();

		u_checker.start_test("backpressure");
		for (int i = 0; i < 40; i++) bus_read(ram_addrs[rand_below(200)], 20);
		close_test();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d", u_checker.tests_run,
			u_checker.tests_failed, u_checker.checks, u_checker.errors);
		if (u_checker.errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: all.f
common/soc_pkg.sv
interconnect/axi_decoder.sv
hdl/axi_ram.sv
hdl/boot_ctrl.sv
uart/axi_uart_tx.sv
hdl/soc_top.sv
tests/soc_asserts.sv
tests/soc_checker.sv
tests/tb_soc_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_top -o tb_soc_top \
	-f all.f && ./obj_dir/tb_soc_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation completed without errors"
exit 0
